// ==== sources.f ====
verilog/atc_msg_pkg.sv
verilog/atc_cfg_pkg.sv
verilog/plane_fifo.sv
verilog/id_pool.sv
verilog/runway_table.sv
verilog/tower_fsm.sv
verilog/atc_top.sv
test/atc_tb.sv

// ==== Bender.yml ====
package:
  name: atc_tower

sources:
  - verilog/atc_msg_pkg.sv
  - verilog/atc_cfg_pkg.sv
  - verilog/plane_fifo.sv
  - verilog/id_pool.sv
  - verilog/runway_table.sv
  - verilog/tower_fsm.sv
  - verilog/atc_top.sv
  - target: test
    files:
      - test/atc_tb.sv

// ==== test/atc_tb.sv ====
module atc_tb;

	localparam int max_cycles = 4000; // Roughly ten times a normal run.

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic [atc_msg_pkg::word_w-1:0] req_data = '0;
	logic req_valid = 1'b0;
	logic req_ready;
	logic [atc_msg_pkg::word_w-1:0] reply_data;
	logic reply_valid;
	logic reply_ready = 1'b0;
	logic [atc_cfg_pkg::num_runways-1:0] runway_busy;

	logic [atc_msg_pkg::word_w-1:0] expected [$];
	string test_name = "reset";
	int errors = 0;
	int checks = 0;
	int test_base = 0;
	int cycle = 0;
	int stall_until = 0;
	logic random_ready = 1'b0;
	logic saw_backpressure = 1'b0;

	atc_top atc_top_i (
		.clock(clock),
		.reset(reset),
		.req_data(req_data),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.reply_data(reply_data),
		.reply_valid(reply_valid),
		.reply_ready(reply_ready),
		.runway_busy(runway_busy)
	);

	initial begin
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= max_cycles) begin
			$display("Timeout in test %s after %0d cycles, run stopped", test_name, cycle);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Reply sink. Stalled for a stretch, then random, else always ready.
	always @(posedge clock) begin
		if (cycle < stall_until)
			reply_ready <= 1'b0;
		else if (random_ready)
			reply_ready <= 1'($urandom() % 2);
		else
			reply_ready <= 1'b1;
	end

	function automatic logic [atc_msg_pkg::word_w-1:0] pack_word(
		input logic [atc_cfg_pkg::id_w-1:0] id,
		input logic [atc_msg_pkg::type_w-1:0] kind,
		input logic [atc_msg_pkg::action_w-1:0] action
	);
		return {id, kind, action};
	endfunction

	task automatic check_eq(input logic [8:0] want, input logic [8:0] got);
		checks++;
		assert (got === want)
		else begin
			errors++;
			$display("ERR %s expected %h actual %h", test_name, want, got);
		end
	endtask

	// Sampled mid-cycle, so a handshake seen here completes at the next edge.
	always @(negedge clock) begin
		if (!reset && req_valid && !req_ready)
			saw_backpressure <= 1'b1;
		if (!reset && reply_valid && reply_ready) begin
			if (expected.size() == 0) begin
				errors++;
				$display("Test %s: reply %h arrived when none was due", test_name, reply_data);
			end else begin
				check_eq(expected.pop_front(), reply_data);
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		reply_valid && !reply_ready |=> reply_valid && $stable(reply_data))
	else begin
		errors++;
		$display("Test %s: stalled reply word changed or vanished", test_name);
	end

	task automatic send_word(input logic [8:0] w);
		@(posedge clock);
		req_data <= w;
		req_valid <= 1'b1;
		@(negedge clock);
		while (!req_ready)
			@(negedge clock);
		@(posedge clock);
		req_valid <= 1'b0;
	endtask

	task automatic send_expect(input logic [8:0] w, input logic [8:0] reply);
		expected.push_back(reply);
		send_word(w);
	endtask

	task automatic drain;
		while (expected.size() != 0)
			@(negedge clock);
	endtask

	task automatic ask_id(input logic pool_full, input logic [3:0] grant);
		send_expect(pack_word(4'd0, atc_msg_pkg::msg_id_request, 2'b00),
			pack_word(pool_full ? 4'd0 : grant, atc_msg_pkg::rep_id, {2{pool_full}}));
	endtask

	task automatic ask_runway(input logic [3:0] id, input logic landing, input logic [2:0] code);
		send_expect(pack_word(id, atc_msg_pkg::msg_request, {landing, 1'b0}),
			pack_word(id, code, 2'b00));
	endtask

	task automatic send_unknown(input logic [3:0] id, input logic [2:0] kind);
		send_expect(pack_word(id, kind, 2'b00), pack_word(id, atc_msg_pkg::rep_say_again, 2'b00));
	endtask

	task automatic vacate(input logic [3:0] id, input logic rw);
		send_word(pack_word(id, atc_msg_pkg::msg_vacated, {1'b0, rw}));
	endtask

	task automatic expect_clear(input logic [3:0] id, input logic landing, input logic rw);
		expected.push_back(pack_word(id, atc_msg_pkg::rep_clear, {landing, rw}));
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_base = errors;
	endtask

	task automatic end_test;
		drain();
		$display("Test %s finished with %0d errors", test_name, errors - test_base);
	endtask

	initial begin
		void'($urandom(54382));
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_eq(9'd0, 9'(runway_busy));
		check_eq(9'd0, 9'(reply_valid));
		check_eq(9'd1, 9'(req_ready));
		end_test();

		begin_test("id_alloc");
		for (int i = 0; i < 16; i++)
			ask_id(1'b0, 4'(i));
		ask_id(1'b1, 4'd0);
		end_test();

		begin_test("clearance");
		ask_runway(4'd0, 1'b0, atc_msg_pkg::rep_hold);
		expect_clear(4'd0, 1'b0, 1'b0);
		drain();
		ask_runway(4'd1, 1'b0, atc_msg_pkg::rep_hold);
		expect_clear(4'd1, 1'b0, 1'b1);
		drain();
		check_eq(9'b11, 9'(runway_busy));
		end_test();

		begin_test("release");
		ask_runway(4'd2, 1'b0, atc_msg_pkg::rep_hold);
		drain();
		repeat (8) @(negedge clock); // No clear may show up while both runways are held.
		expect_clear(4'd2, 1'b0, 1'b1); // Plane 1 leaves runway 1.
		vacate(4'd1, 1'b1);
		drain();
		vacate(4'd5, 1'b0); // Not the holder of runway 0.
		ask_id(1'b0, 4'd1);
		drain();
		check_eq(9'b11, 9'(runway_busy));
		end_test();

		// Three clearances so far, so landing has priority now.
		begin_test("alternation");
		ask_runway(4'd3, 1'b0, atc_msg_pkg::rep_hold);
		ask_runway(4'd4, 1'b0, atc_msg_pkg::rep_hold);
		ask_runway(4'd6, 1'b1, atc_msg_pkg::rep_hold);
		ask_runway(4'd7, 1'b1, atc_msg_pkg::rep_hold);
		drain();
		expect_clear(4'd6, 1'b1, 1'b0);
		vacate(4'd0, 1'b0);
		drain();
		expect_clear(4'd3, 1'b0, 1'b1);
		vacate(4'd2, 1'b1);
		drain();
		expect_clear(4'd7, 1'b1, 1'b0);
		vacate(4'd6, 1'b0);
		drain();
		expect_clear(4'd4, 1'b0, 1'b1); // Only takeoff is left.
		vacate(4'd3, 1'b1);
		end_test();

		begin_test("rejections");
		send_word(pack_word(4'd0, atc_msg_pkg::msg_request, 2'b00)); // ID 0 is free.
		send_unknown(4'd8, atc_msg_pkg::msg_emergency);
		send_unknown(4'd9, 3'b100);
		ask_id(1'b0, 4'd0);
		ask_id(1'b0, 4'd2);
		ask_id(1'b0, 4'd3);
		ask_id(1'b0, 4'd5);
		ask_id(1'b0, 4'd6);
		for (int i = 8; i < 12; i++)
			ask_runway(4'(i), 1'b0, atc_msg_pkg::rep_hold);
		ask_runway(4'd12, 1'b0, atc_msg_pkg::rep_divert);
		ask_id(1'b0, 4'd12);
		end_test();

		begin_test("backpressure");
		@(posedge clock);
		stall_until <= cycle + 40;
		random_ready <= 1'b1;
		ask_runway(4'd13, 1'b1, atc_msg_pkg::rep_hold);
		ask_runway(4'd14, 1'b1, atc_msg_pkg::rep_hold);
		send_unknown(4'd15, atc_msg_pkg::msg_emergency);
		ask_id(1'b1, 4'd0);
		ask_runway(4'd15, 1'b1, atc_msg_pkg::rep_hold);
		ask_runway(4'd0, 1'b1, atc_msg_pkg::rep_hold);
		ask_runway(4'd1, 1'b1, atc_msg_pkg::rep_divert);
		send_unknown(4'd3, 3'b011);
		ask_id(1'b0, 4'd1);
		ask_id(1'b1, 4'd0);
		ask_runway(4'd2, 1'b0, atc_msg_pkg::rep_divert);
		ask_id(1'b0, 4'd2);
		drain();
		assert (saw_backpressure)
		else begin
			errors++;
			$display("Test %s: request queue never pushed back", test_name);
		end
		check_eq(9'b11, 9'(runway_busy));
		end_test();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== verilog/atc_top.sv ====
module atc_top (
	input logic clock,
	input logic reset,
	input logic [atc_msg_pkg::word_w-1:0] req_data,
	input logic req_valid,
	output logic req_ready,
	output logic [atc_msg_pkg::word_w-1:0] reply_data,
	output logic reply_valid,
	input logic reply_ready,
	output logic [atc_cfg_pkg::num_runways-1:0] runway_busy
);

	logic [atc_msg_pkg::word_w-1:0] req_head;
	logic req_avail;
	logic req_pop;
	logic takeoff_push;
	logic takeoff_ready;
	logic [atc_cfg_pkg::id_w-1:0] takeoff_head;
	logic takeoff_valid;
	logic takeoff_pop;
	logic landing_push;
	logic landing_ready;
	logic [atc_cfg_pkg::id_w-1:0] landing_head;
	logic landing_valid;
	logic landing_pop;
	logic [atc_msg_pkg::word_w-1:0] reply_word;
	logic reply_push;
	logic reply_room;
	logic id_take;
	logic id_release;
	logic [atc_cfg_pkg::id_w-1:0] id_release_id;
	logic [atc_cfg_pkg::num_planes-1:0] id_taken;
	logic [atc_cfg_pkg::id_w-1:0] id_grant;
	logic id_full;
	logic rw_lock;
	logic rw_unlock;
	logic rw_sel;
	logic [atc_cfg_pkg::id_w-1:0] rw_plane;

	plane_fifo request_q (
		.clock(clock),
		.reset(reset),
		.in_data(req_data),
		.in_valid(req_valid),
		.in_ready(req_ready),
		.out_data(req_head),
		.out_valid(req_avail),
		.out_ready(req_pop)
	);

	// Plane queues take their IDs off the sequencer's plane bus.
	plane_fifo #(.width(atc_cfg_pkg::id_w)) takeoff_q (
		.clock(clock),
		.reset(reset),
		.in_data(rw_plane),
		.in_valid(takeoff_push),
		.in_ready(takeoff_ready),
		.out_data(takeoff_head),
		.out_valid(takeoff_valid),
		.out_ready(takeoff_pop)
	);

	plane_fifo #(.width(atc_cfg_pkg::id_w)) landing_q (
		.clock(clock),
		.reset(reset),
		.in_data(rw_plane),
		.in_valid(landing_push),
		.in_ready(landing_ready),
		.out_data(landing_head),
		.out_valid(landing_valid),
		.out_ready(landing_pop)
	);

	plane_fifo reply_q (
		.clock(clock),
		.reset(reset),
		.in_data(reply_word),
		.in_valid(reply_push),
		.in_ready(reply_room),
		.out_data(reply_data),
		.out_valid(reply_valid),
		.out_ready(reply_ready)
	);

	id_pool ids (
		.clock(clock),
		.reset(reset),
		.take(id_take),
		.release_en(id_release),
		.release_id(id_release_id),
		.grant_id(id_grant),
		.taken(id_taken),
		.full(id_full)
	);

	runway_table runways (
		.clock(clock),
		.reset(reset),
		.lock(rw_lock),
		.unlock(rw_unlock),
		.sel_runway(rw_sel),
		.plane_id(rw_plane),
		.busy(runway_busy)
	);

	tower_fsm tower (
		.clock(clock),
		.reset(reset),
		.req_data(req_head),
		.req_valid(req_avail),
		.req_pop(req_pop),
		.takeoff_push(takeoff_push),
		.takeoff_full(!takeoff_ready),
		.takeoff_head(takeoff_head),
		.takeoff_valid(takeoff_valid),
		.takeoff_pop(takeoff_pop),
		.landing_push(landing_push),
		.landing_full(!landing_ready),
		.landing_head(landing_head),
		.landing_valid(landing_valid),
		.landing_pop(landing_pop),
		.reply_data(reply_word),
		.reply_push(reply_push),
		.reply_full(!reply_room),
		.id_take(id_take),
		.id_release(id_release),
		.id_release_id(id_release_id),
		.id_taken(id_taken),
		.id_grant(id_grant),
		.id_full(id_full),
		.rw_lock(rw_lock),
		.rw_unlock(rw_unlock),
		.rw_sel(rw_sel),
		.rw_plane(rw_plane),
		.rw_busy(runway_busy)
	);

endmodule

// ==== verilog/tower_fsm.sv ====
module tower_fsm (
	input logic clock,
	input logic reset,
	input logic [atc_msg_pkg::word_w-1:0] req_data,
	input logic req_valid,
	output logic req_pop,
	output logic takeoff_push,
	input logic takeoff_full,
	input logic [atc_cfg_pkg::id_w-1:0] takeoff_head,
	input logic takeoff_valid,
	output logic takeoff_pop,
	output logic landing_push,
	input logic landing_full,
	input logic [atc_cfg_pkg::id_w-1:0] landing_head,
	input logic landing_valid,
	output logic landing_pop,
	output logic [atc_msg_pkg::word_w-1:0] reply_data,
	output logic reply_push,
	input logic reply_full,
	output logic id_take,
	output logic id_release,
	output logic [atc_cfg_pkg::id_w-1:0] id_release_id,
	input logic [atc_cfg_pkg::num_planes-1:0] id_taken,
	input logic [atc_cfg_pkg::id_w-1:0] id_grant,
	input logic id_full,
	output logic rw_lock,
	output logic rw_unlock,
	output logic rw_sel,
	output logic [atc_cfg_pkg::id_w-1:0] rw_plane,
	input logic [atc_cfg_pkg::num_runways-1:0] rw_busy
);

	typedef enum logic [2:0] {
		idle,
		decode,
		reply,
		schedule,
		clear
	} state_e;

	state_e state;
	state_e state_next;
	logic [atc_msg_pkg::word_w-1:0] req_q;
	logic [atc_msg_pkg::word_w-1:0] reply_next;
	logic reply_load;
	logic prio_landing;
	logic flip_prio;
	logic [atc_cfg_pkg::id_w-1:0] req_id;
	atc_msg_pkg::msg_type_e req_type;
	logic [atc_msg_pkg::action_w-1:0] req_action;
	logic registered;
	logic runway_free;
	logic any_waiting;
	logic pick_landing;
	logic [atc_cfg_pkg::id_w-1:0] head_id;

	assign req_id = req_q[atc_msg_pkg::id_lsb +: atc_cfg_pkg::id_w];
	assign req_type = atc_msg_pkg::msg_type_e'(req_q[atc_msg_pkg::type_lsb +: atc_msg_pkg::type_w]);
	assign req_action = req_q[atc_msg_pkg::action_lsb +: atc_msg_pkg::action_w];
	assign registered = id_taken[req_id];
	assign id_release_id = req_id;

	assign runway_free = !(&rw_busy);
	assign any_waiting = takeoff_valid || landing_valid;

	// A lone queue always wins; with both waiting the flag decides.
	assign pick_landing = landing_valid && (!takeoff_valid || prio_landing);
	assign head_id = pick_landing ? landing_head : takeoff_head;

	always_comb begin
		state_next = state;
		req_pop = 1'b0;
		takeoff_push = 1'b0;
		takeoff_pop = 1'b0;
		landing_push = 1'b0;
		landing_pop = 1'b0;
		reply_push = 1'b0;
		id_take = 1'b0;
		id_release = 1'b0;
		rw_lock = 1'b0;
		rw_unlock = 1'b0;
		rw_sel = req_action[0];
		rw_plane = req_id; // Also the data pushed into the plane queues.
		reply_next = reply_data;
		reply_load = 1'b0;
		flip_prio = 1'b0;
		case (state)
			idle: begin
				if (req_valid) begin
					req_pop = 1'b1;
					state_next = decode;
				end else if (runway_free && any_waiting) begin
					state_next = schedule;
				end
			end
			decode: begin
				state_next = idle; // Dropped and vacated requests send nothing.
				case (req_type)
					atc_msg_pkg::msg_request: begin
						if (registered) begin
							state_next = reply;
							reply_load = 1'b1;
							if (req_action[1] ? landing_full : takeoff_full) begin
								id_release = 1'b1;
								reply_next = {req_id, atc_msg_pkg::rep_divert,
									atc_msg_pkg::act_none};
							end else begin
								takeoff_push = !req_action[1];
								landing_push = req_action[1];
								reply_next = {req_id, atc_msg_pkg::rep_hold,
									atc_msg_pkg::act_none};
							end
						end
					end
					atc_msg_pkg::msg_vacated: begin
						if (registered) begin
							id_release = 1'b1;
							rw_unlock = 1'b1;
						end
					end
					atc_msg_pkg::msg_id_request: begin
						state_next = reply;
						reply_load = 1'b1;
						if (id_full) begin
							reply_next = {{atc_cfg_pkg::id_w{1'b0}}, atc_msg_pkg::rep_id,
								atc_msg_pkg::act_id_invalid};
						end else begin
							id_take = 1'b1;
							reply_next = {id_grant, atc_msg_pkg::rep_id, atc_msg_pkg::act_none};
						end
					end
					default: begin
						// Emergency and unknown types.
						if (registered) begin
							state_next = reply;
							reply_load = 1'b1;
							reply_next = {req_id, atc_msg_pkg::rep_say_again,
								atc_msg_pkg::act_none};
						end
					end
				endcase
			end
			schedule: begin
				takeoff_pop = !pick_landing;
				landing_pop = pick_landing;
				rw_lock = 1'b1;
				rw_sel = rw_busy[0]; // Lowest free runway of the two.
				rw_plane = head_id;
				flip_prio = 1'b1;
				reply_load = 1'b1;
				reply_next = {head_id, atc_msg_pkg::rep_clear, pick_landing, rw_busy[0]};
				state_next = clear;
			end
			reply, clear: begin
				// Hold the reply until the reply queue has room.
				if (!reply_full) begin
					reply_push = 1'b1;
					state_next = idle;
				end
			end
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (req_pop)
			req_q <= req_data;
		if (reply_load)
			reply_data <= reply_next;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			prio_landing <= 1'b0; // Takeoff goes first.
		end else begin
			state <= state_next;
			if (flip_prio)
				prio_landing <= !prio_landing;
		end
	end

endmodule

// ==== verilog/runway_table.sv ====
module runway_table (
	input logic clock,
	input logic reset,
	input logic lock,
	input logic unlock,
	input logic sel_runway,
	input logic [atc_cfg_pkg::id_w-1:0] plane_id,
	output logic [atc_cfg_pkg::num_runways-1:0] busy
);

	logic [atc_cfg_pkg::id_w-1:0] holder [atc_cfg_pkg::num_runways];
	logic owner_match;

	// Only the plane that holds the runway may free it.
	assign owner_match = holder[sel_runway] == plane_id;

	always_ff @(posedge clock) begin
		if (lock)
			holder[sel_runway] <= plane_id;
	end

	always_ff @(posedge clock) begin
		if (reset)
			busy <= '0;
		else if (lock)
			busy[sel_runway] <= 1'b1;
		else if (unlock && owner_match)
			busy[sel_runway] <= 1'b0;
	end

endmodule

// ==== verilog/id_pool.sv ====
module id_pool (
	input logic clock,
	input logic reset,
	input logic take,
	input logic release_en,
	input logic [atc_cfg_pkg::id_w-1:0] release_id,
	output logic [atc_cfg_pkg::id_w-1:0] grant_id,
	output logic [atc_cfg_pkg::num_planes-1:0] taken,
	output logic full
);

	assign full = &taken;

	// Lowest free ID. Scanning downward leaves the lowest one.
	always_comb begin
		grant_id = '0;
		for (int i = atc_cfg_pkg::num_planes - 1; i >= 0; i--) begin
			if (!taken[i])
				grant_id = i[atc_cfg_pkg::id_w-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			taken <= '0;
		else if (release_en)
			taken[release_id] <= 1'b0; // Release has priority over a grant.
		else if (take && !full)
			taken[grant_id] <= 1'b1;
	end

endmodule

// ==== verilog/plane_fifo.sv ====
module plane_fifo #(
	parameter int width = atc_msg_pkg::word_w
) (
	input logic clock,
	input logic reset,
	input logic [width-1:0] in_data,
	input logic in_valid,
	output logic in_ready,
	output logic [width-1:0] out_data,
	output logic out_valid,
	input logic out_ready
);

	logic [width-1:0] mem [atc_cfg_pkg::queue_depth];
	logic [$clog2(atc_cfg_pkg::queue_depth)-1:0] wr_ptr;
	logic [$clog2(atc_cfg_pkg::queue_depth)-1:0] rd_ptr;
	logic [$clog2(atc_cfg_pkg::queue_depth+1)-1:0] count;
	logic push;
	logic pop;

	assign in_ready = count != atc_cfg_pkg::queue_depth;
	assign out_valid = count != 0;
	assign out_data = mem[rd_ptr]; // Head shows without a read.
	assign push = in_valid && in_ready;
	assign pop = out_ready && out_valid;

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == atc_cfg_pkg::queue_depth - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == atc_cfg_pkg::queue_depth - 1) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== verilog/atc_cfg_pkg.sv ====
package atc_cfg_pkg;

	// Number of plane IDs the tower can hand out.
	localparam int num_planes = 16;

	// Width of a plane ID.
	localparam int id_w = 4;

	// Depth of every queue in the tower.
	localparam int queue_depth = 4;

	// Runways under control of the tower.
	localparam int num_runways = 2;

endpackage

// ==== verilog/atc_msg_pkg.sv ====
package atc_msg_pkg;

	// Request and reply words share one layout: ID, type, action.
	localparam int word_w = 9;
	localparam int type_w = 3;
	localparam int action_w = 2;

	localparam int action_lsb = 0;
	localparam int type_lsb = action_lsb + action_w;
	localparam int id_lsb = type_lsb + type_w; // Plane ID sits in bits 8..5.

	// Request types.
	typedef enum logic [type_w-1:0] {
		msg_request = 3'b000, // Action bit 1 picks landing.
		msg_vacated = 3'b001, // Action bit 0 names the runway.
		msg_emergency = 3'b010, // Not supported, answered with say again.
		msg_id_request = 3'b111
	} msg_type_e;

	// Reply types.
	typedef enum logic [type_w-1:0] {
		rep_clear = 3'b011,
		rep_hold = 3'b100,
		rep_say_again = 3'b101,
		rep_divert = 3'b110,
		rep_id = 3'b111
	} reply_code_e;

	// Action values for replies that carry no runway.
	localparam logic [action_w-1:0] act_none = 2'b00;
	localparam logic [action_w-1:0] act_id_invalid = 2'b11; // Pool exhausted.

endpackage
